// File: logic/eeprom_pkg.sv
package eeprom_pkg;

    // 11-bit word address, bits 10:8 pick one of eight 256-byte blocks
    typedef logic [10:0] addr_t;

    typedef logic [7:0] data_t;

    // device type code, leads every control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

    // bit engine opcodes
    typedef enum logic [1:0] {
        CMD_START,  // also used for repeated start
        CMD_STOP,
        CMD_WRITE,  // 8 bits out, ack sampled
        CMD_READ    // 8 bits in, master nack
    } bit_cmd_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_W,
        SEQ_ADDR,
        SEQ_DATA_W,
        SEQ_RESTART,
        SEQ_CTRL_R,
        SEQ_DATA_R,
        SEQ_STOP,
        SEQ_DONE
    } seq_state_t;

endpackage

// File: logic/i2c_bit_engine.sv
module i2c_bit_engine #(
    parameter int CLK_DIV = 2  // CLK cycles per SCL half period, at least 2
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  eeprom_pkg::data_t    tx_byte,
    input  logic                 sda_in,
    output logic                 cmd_done,
    output eeprom_pkg::data_t    rx_byte,
    output logic                 ack_ok,
    output logic                 scl,
    output logic                 sda_low
);

    localparam int DIV_W = $clog2(CLK_DIV);

    // positions inside one half period
    localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(CLK_DIV - 1);
    localparam logic [DIV_W-1:0] DRIVE_AT  = DIV_W'(CLK_DIV / 2 - 1);
    localparam logic [DIV_W-1:0] SAMPLE_AT = DIV_W'(CLK_DIV / 2);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_LOW,   // scl low half
        PH_HIGH   // scl high half
    } phase_t;

    phase_t               phase;
    eeprom_pkg::bit_cmd_t cur_cmd;
    eeprom_pkg::data_t    shift_q;
    logic [DIV_W-1:0]     div_cnt;
    logic [3:0]           bit_cnt;  // 0..7 data, 8 is the ack slot

    logic in_progress;
    logic accept;
    logic half_end;
    logic drive_now;
    logic sample_now;
    logic is_byte;
    logic last_bit;
    logic ack_slot;
    logic low_drive;

    assign in_progress = (phase != PH_IDLE);
    assign accept      = cmd_valid && !in_progress;
    assign half_end    = (div_cnt == DIV_LAST);
    assign drive_now   = (div_cnt == DRIVE_AT);
    assign sample_now  = (div_cnt == SAMPLE_AT);
    assign ack_slot    = (bit_cnt == 4'd8);

    assign is_byte  = (cur_cmd == eeprom_pkg::CMD_WRITE) || (cur_cmd == eeprom_pkg::CMD_READ);
    assign last_bit = is_byte ? ack_slot : 1'b1;  // start and stop are one scl period

    // sda level set in the middle of the low half
    always_comb
    begin
        case (cur_cmd)
            eeprom_pkg::CMD_START:
                low_drive = 1'b0;  // release so a repeated start sees sda high
            eeprom_pkg::CMD_STOP:
                low_drive = 1'b1;  // pull low, released again while scl high
            eeprom_pkg::CMD_WRITE:
                low_drive = ack_slot ? 1'b0 : ~shift_q[7];
            default:
                low_drive = 1'b0;  // read bits and the master nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= PH_IDLE;
            cur_cmd  <= eeprom_pkg::CMD_STOP;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            cmd_done <= 1'b0;
            ack_ok   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            case (phase)
                PH_IDLE:
                begin
                    if (accept)
                    begin
                        cur_cmd <= cmd;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        scl     <= 1'b0;  // every command opens with a low half
                        phase   <= PH_LOW;
                    end
                end
                PH_LOW:
                begin
                    if (drive_now)
                        sda_low <= low_drive;
                    if (half_end)
                    begin
                        div_cnt <= '0;
                        scl     <= 1'b1;
                        phase   <= PH_HIGH;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                PH_HIGH:
                begin
                    // start and stop edges, sda moves while scl is high
                    if (drive_now && !is_byte)
                        sda_low <= (cur_cmd == eeprom_pkg::CMD_START);
                    if (sample_now && ack_slot && cur_cmd == eeprom_pkg::CMD_WRITE)
                        ack_ok <= ~sda_in;
                    if (half_end)
                    begin
                        div_cnt <= '0;
                        if (last_bit)
                        begin
                            phase    <= PH_IDLE;  // scl stays high
                            cmd_done <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            scl     <= 1'b0;
                            phase   <= PH_LOW;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // byte shifters
    always_ff @(posedge CLK)
    begin
        if (accept)
            shift_q <= tx_byte;
        else if (phase == PH_LOW && drive_now && !ack_slot)
            shift_q <= {shift_q[6:0], 1'b0};  // msb first

        if (phase == PH_HIGH && sample_now && !ack_slot && cur_cmd == eeprom_pkg::CMD_READ)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

// File: logic/eeprom_sequencer.sv
module eeprom_sequencer (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::addr_t    addr,
    input  eeprom_pkg::data_t    wr_data,
    input  logic                 cmd_done,
    input  eeprom_pkg::data_t    rx_byte,
    input  logic                 ack_ok,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output eeprom_pkg::data_t    rd_data,
    output logic                 cmd_valid,
    output eeprom_pkg::bit_cmd_t cmd,
    output eeprom_pkg::data_t    tx_byte
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t next_state;
    eeprom_pkg::addr_t      addr_q;
    eeprom_pkg::data_t      data_q;

    logic is_read;
    logic waiting;  // command handed to the engine, not yet finished
    logic accept;
    logic byte_sent;

    assign busy   = (state != eeprom_pkg::SEQ_IDLE);
    assign done   = (state == eeprom_pkg::SEQ_DONE);
    assign accept = (state == eeprom_pkg::SEQ_IDLE) && (wr || rd);

    assign byte_sent = (cmd == eeprom_pkg::CMD_WRITE);

    // engine command and byte for the current state
    always_comb
    begin
        cmd     = eeprom_pkg::CMD_STOP;
        tx_byte = '0;
        case (state)
            eeprom_pkg::SEQ_START,
            eeprom_pkg::SEQ_RESTART:
                cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::SEQ_CTRL_W:
            begin
                cmd     = eeprom_pkg::CMD_WRITE;
                tx_byte = {eeprom_pkg::CTRL_CODE, addr_q[10:8], 1'b0};
            end
            eeprom_pkg::SEQ_ADDR:
            begin
                cmd     = eeprom_pkg::CMD_WRITE;
                tx_byte = addr_q[7:0];  // word address in the block
            end
            eeprom_pkg::SEQ_DATA_W:
            begin
                cmd     = eeprom_pkg::CMD_WRITE;
                tx_byte = data_q;
            end
            eeprom_pkg::SEQ_CTRL_R:
            begin
                cmd     = eeprom_pkg::CMD_WRITE;
                tx_byte = {eeprom_pkg::CTRL_CODE, addr_q[10:8], 1'b1};
            end
            eeprom_pkg::SEQ_DATA_R:
                cmd = eeprom_pkg::CMD_READ;
            default:
                cmd = eeprom_pkg::CMD_STOP;
        endcase
    end

    // successor once the engine reports cmd_done
    always_comb
    begin
        case (state)
            eeprom_pkg::SEQ_START:   next_state = eeprom_pkg::SEQ_CTRL_W;
            eeprom_pkg::SEQ_CTRL_W:  next_state = eeprom_pkg::SEQ_ADDR;
            eeprom_pkg::SEQ_ADDR:
                next_state = is_read ? eeprom_pkg::SEQ_RESTART : eeprom_pkg::SEQ_DATA_W;
            eeprom_pkg::SEQ_DATA_W:  next_state = eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_RESTART: next_state = eeprom_pkg::SEQ_CTRL_R;
            eeprom_pkg::SEQ_CTRL_R:  next_state = eeprom_pkg::SEQ_DATA_R;
            eeprom_pkg::SEQ_DATA_R:  next_state = eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_STOP:    next_state = eeprom_pkg::SEQ_DONE;
            default:                 next_state = eeprom_pkg::SEQ_IDLE;
        endcase
        if (byte_sent && !ack_ok)
            next_state = eeprom_pkg::SEQ_STOP;  // no ack, close the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::SEQ_IDLE;
            waiting   <= 1'b0;
            cmd_valid <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                eeprom_pkg::SEQ_IDLE:
                begin
                    if (accept)
                    begin
                        nack  <= 1'b0;
                        state <= eeprom_pkg::SEQ_START;
                    end
                end
                eeprom_pkg::SEQ_DONE:
                    state <= eeprom_pkg::SEQ_IDLE;
                default:
                begin
                    if (!waiting)
                    begin
                        cmd_valid <= 1'b1;  // one pulse per state
                        waiting   <= 1'b1;
                    end
                    else if (cmd_done)
                    begin
                        waiting <= 1'b0;
                        if (byte_sent && !ack_ok)
                            nack <= 1'b1;
                        state <= next_state;
                    end
                end
            endcase
        end
    end

    // request and result registers
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            data_q  <= wr_data;
            is_read <= !wr;  // write wins over read
        end
        if (cmd_done && state == eeprom_pkg::SEQ_DATA_R)
            rd_data <= rx_byte;
    end

endmodule

// File: logic/eeprom_ctrl.sv
module eeprom_ctrl #(
    parameter int CLK_DIV = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wr_data,
    input  logic              sda_in,
    output logic              busy,
    output logic              done,
    output logic              nack,
    output eeprom_pkg::data_t rd_data,
    output logic              scl,
    output logic              sda_low
);

    logic                 cmd_valid;
    logic                 cmd_done;
    logic                 ack_ok;
    eeprom_pkg::bit_cmd_t cmd;
    eeprom_pkg::data_t    tx_byte;
    eeprom_pkg::data_t    rx_byte;

    eeprom_sequencer u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rd_data   (rd_data),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .scl       (scl),
        .sda_low   (sda_low)
    );

endmodule

// File: verification/eeprom_model.sv
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic ack_enable,
    output logic sda_low
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} mode_t;

    eeprom_pkg::data_t mem [0:2047];
    eeprom_pkg::data_t shreg;
    eeprom_pkg::data_t rbyte;
    logic [2:0]        block;
    logic [7:0]        word;
    mode_t             mode;
    mode_t             next_mode;
    int                bit_idx;
    logic              clocked;  // a bit was clocked since the last start
    logic              scl_q;
    logic              sda_q;
    int                i;

    // one process watches both wires and owns all of the slave state
    initial
    begin
        for (i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {i[10:8], 5'b01101};
        mode = M_IDLE;
        next_mode = M_IDLE;
        sda_low = 1'b0;
        clocked = 1'b0;
        bit_idx = 0;
        scl_q = 1'b1;
        sda_q = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl && !scl_q && mode != M_IDLE)
            begin
                if (bit_idx < 8 && mode != M_RDATA)
                    shreg = {shreg[6:0], sda};
                clocked = 1'b1;
            end
            else if (!scl && scl_q && clocked)
            begin
                clocked = 1'b0;
                sda_low = 1'b0;
                if (bit_idx == 8)
                begin
                    bit_idx = 0;
                    mode = next_mode;
                    if (mode == M_RDATA)
                    begin
                        rbyte = mem[{block, word}];
                        sda_low = ~rbyte[7];
                    end
                end
                else if (bit_idx == 7)
                begin
                    bit_idx = 8;  // ack slot
                    next_mode = M_IDLE;
                    case (mode)
                        M_CTRL:
                        begin
                            if (shreg[7:4] == eeprom_pkg::CTRL_CODE)
                            begin
                                block = shreg[3:1];
                                next_mode = shreg[0] ? M_RDATA : M_ADDR;
                                if (shreg[0] && !ack_enable)
                                    next_mode = M_IDLE;  // never drive unacked read data
                                sda_low = ack_enable;
                            end
                        end
                        M_ADDR:
                        begin
                            word = shreg;
                            next_mode = M_WDATA;
                            sda_low = ack_enable;
                        end
                        M_WDATA:
                        begin
                            // a master that ignores a nack still lands here
                            mem[{block, word}] = shreg;
                            sda_low = ack_enable;
                        end
                        default:
                            sda_low = 1'b0;  // master answers a read byte
                    endcase
                end
                else
                begin
                    bit_idx++;
                    if (mode == M_RDATA)
                        sda_low = ~rbyte[7 - bit_idx];
                end
            end
            else if (scl && scl_q && sda_q && !sda)
            begin
                mode = M_CTRL;  // start or repeated start
                bit_idx = 0;
                clocked = 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                mode = M_IDLE;  // stop
                clocked = 1'b0;
                sda_low = 1'b0;
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// File: verification/eeprom_ctrl_props.sv
module eeprom_ctrl_props (
    input logic                 CLK,
    input logic                 RESET,
    input logic                 cmd_valid,
    input logic                 cmd_done,
    input logic                 in_progress,
    input logic                 scl,
    input logic                 sda_low,
    input eeprom_pkg::bit_cmd_t cur_cmd
);

    assert property (@(posedge CLK) disable iff (RESET) cmd_done |=> !cmd_done)
        else $error("cmd_done stayed high for two cycles");

    // only start and stop may move sda under a high scl
    assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_low) && scl && $past(scl) |->
            (cur_cmd == eeprom_pkg::CMD_START || cur_cmd == eeprom_pkg::CMD_STOP))
        else $error("sda changed while scl high during a byte command");

    assert property (@(posedge CLK) disable iff (RESET) in_progress |-> !cmd_valid)
        else $error("cmd_valid arrived while a command was in progress");

endmodule

bind i2c_bit_engine eeprom_ctrl_props u_props (
    .CLK         (CLK),
    .RESET       (RESET),
    .cmd_valid   (cmd_valid),
    .cmd_done    (cmd_done),
    .in_progress (in_progress),
    .scl         (scl),
    .sda_low     (sda_low),
    .cur_cmd     (cur_cmd)
);

// File: verification/eeprom_ctrl_tb.sv
module eeprom_ctrl_tb;

    localparam int CLK_DIV    = 4;
    localparam int PERIOD     = 4;
    localparam int TXN_CYCLES = 100 * CLK_DIV;  // a read takes about 78 * CLK_DIV + 22
    localparam int TXN_COUNT  = 32;             // 31 in the tests, one spare

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic              busy;
    logic              done;
    logic              nack;
    logic              scl;
    logic              sda_low;
    logic              sda_in;
    logic              model_sda_low;
    logic              ack_enable;
    eeprom_pkg::addr_t addr;
    eeprom_pkg::addr_t saved_addr;
    eeprom_pkg::data_t wr_data;
    eeprom_pkg::data_t rd_data;
    eeprom_pkg::data_t shadow [0:2047];  // only written addresses are compared
    logic [15:0]       lfsr_state;
    int                mismatches;
    int                failures;

    assign sda_in = !(sda_low || model_sda_low);  // pulled-up wired AND

    eeprom_ctrl #(
        .CLK_DIV (CLK_DIV)
    ) DUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_low (sda_low)
    );

    eeprom_model u_model (
        .scl        (scl),
        .sda        (sda_in),
        .ack_enable (ack_enable),
        .sda_low    (model_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #(PERIOD / 2) CLK = ~CLK;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_flag(input string name, input logic got, input bit exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_data(input string name, input eeprom_pkg::data_t got,
                              input eeprom_pkg::data_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic start_request(input logic is_write, input eeprom_pkg::addr_t a,
                                 input eeprom_pkg::data_t d);
        @(negedge CLK);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        wr = is_write;
        rd = !is_write;
        addr = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic finish_request(input bit exp_nack);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < TXN_CYCLES)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("Error at %0t: no done pulse within %0d cycles", $time, TXN_CYCLES);
            failures++;
        end
        else
            check_flag("nack", nack, exp_nack);
    endtask

    task automatic do_write(input eeprom_pkg::addr_t a, input eeprom_pkg::data_t d);
        start_request(1'b1, a, d);
        finish_request(1'b0);
        shadow[a] = d;
    endtask

    task automatic do_read(input eeprom_pkg::addr_t a);
        start_request(1'b0, a, '0);
        finish_request(1'b0);
        check_data("rd_data", rd_data, shadow[a]);
    endtask

    task automatic reset_values_hold();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_low", sda_low, 1'b0);
    endtask

    task automatic write_then_read();
        saved_addr = eeprom_pkg::addr_t'(random_bits(11));
        do_write(saved_addr, eeprom_pkg::data_t'(random_bits(8)));
        do_read(saved_addr);
    endtask

    // same word in every block, so lost block bits make the bytes alias
    task automatic all_blocks_round_trip();
        logic [7:0] offset;
        int         blk;
        offset = 8'(random_bits(8));
        for (blk = 0; blk < 8; blk++)
            do_write({3'(blk), offset}, eeprom_pkg::data_t'(random_bits(8)));
        for (blk = 0; blk < 8; blk++)
            do_read({3'(blk), offset});
    endtask

    task automatic overwrite_keeps_neighbors();
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t d;
        a = eeprom_pkg::addr_t'(random_bits(11));
        do_write(a - 1'b1, eeprom_pkg::data_t'(random_bits(8)));
        do_write(a, eeprom_pkg::data_t'(random_bits(8)));
        do_write(a + 1'b1, eeprom_pkg::data_t'(random_bits(8)));
        d = eeprom_pkg::data_t'(random_bits(8));
        if (d == shadow[a])
            d = ~d;
        do_write(a, d);
        do_read(a);
        do_read(a - 1'b1);
        do_read(a + 1'b1);
    endtask

    task automatic missing_ack_reports_nack();
        ack_enable = 1'b0;
        start_request(1'b1, saved_addr, ~shadow[saved_addr]);
        finish_request(1'b1);
        start_request(1'b0, saved_addr, '0);
        finish_request(1'b1);
        ack_enable = 1'b1;
        do_read(saved_addr);  // contents untouched by the refused write
    endtask

    task automatic strobe_while_busy_ignored();
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t d;
        int                extra;
        a = eeprom_pkg::addr_t'(random_bits(11));
        d = eeprom_pkg::data_t'(random_bits(8));
        start_request(1'b1, a, d);
        repeat (10) @(negedge CLK);
        wr = 1'b1;
        rd = 1'b1;
        wr_data = ~d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        finish_request(1'b0);
        shadow[a] = d;
        extra = 0;
        repeat (TXN_CYCLES)
        begin
            @(negedge CLK);
            if (done === 1'b1)
                extra++;
        end
        if (extra != 0)
        begin
            $display("Error at %0t: %0d extra done pulses after strobes while busy",
                     $time, extra);
            failures++;
        end
        do_read(a);
    endtask

    initial
    begin
        #(TXN_COUNT * TXN_CYCLES * PERIOD * 2);
        $display("Error: watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wr_data = '0;
        ack_enable = 1'b1;
        lfsr_state = 16'd95;
        mismatches = 0;
        failures = 0;
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        reset_values_hold();
        write_then_read();
        all_blocks_round_trip();
        overwrite_keeps_neighbors();
        missing_ack_reports_nack();
        strobe_while_busy_ignored();
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: eeprom_ctrl.f
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_props.sv
verification/eeprom_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f eeprom_ctrl.f \
    --top-module eeprom_ctrl_tb -o eeprom_ctrl_sim

./obj_dir/eeprom_ctrl_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
